/* src/eth_dma_pkg.sv */
package eth_dma_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [3:0]  strb_t;
	typedef logic [2:0]  desc_idx_t;
	typedef logic [15:0] byte_count_t;
	typedef logic [47:0] mac_t;

	localparam int desc_count = 8;

	// register page and byte offsets within it
	localparam logic [23:0] reg_page = 24'h800000;
	localparam logic [7:0] reg_rx_addr_base = {6'h10, 2'b00};
	localparam logic [7:0] reg_rx_len_base = {6'h18, 2'b00};
	localparam logic [7:0] reg_enable = {6'h30, 2'b00};
	localparam logic [7:0] reg_rx_status = {6'h31, 2'b00};
	localparam logic [7:0] reg_rx_clear = {6'h32, 2'b00};

	localparam mac_t own_mac = 48'haa_bb_cc_dd_ee_ff;
	localparam mac_t bcast_mac = 48'hff_ff_ff_ff_ff_ff;

	// cycles between interrupt checks
	localparam int rx_irq_interval = 200;
	localparam int word_bytes = 4;

	// bytes carried by a tail-aligned keep pattern
	function automatic logic [2:0] keep_bytes(strb_t keep);
		case (keep)
			4'hf: return 3'd4;
			4'h7: return 3'd3;
			4'h3: return 3'd2;
			4'h1: return 3'd1;
			default: return 3'd0;
		endcase
	endfunction

endpackage

/* src/heap_bus_if.sv */
`timescale 1ns/100ps

interface heap_bus_if import eth_dma_pkg::*; ();

	logic  valid;
	logic  ready;
	addr_t addr;
	word_t wdata;
	strb_t wstrb;
	word_t rdata;

	modport master (
		output valid, addr, wdata, wstrb,
		input  ready, rdata
	);

	modport slave (
		input  valid, addr, wdata, wstrb,
		output ready, rdata
	);

endinterface

/* src/rx_beat_if.sv */
`timescale 1ns/100ps

interface rx_beat_if import eth_dma_pkg::*; ();

	logic  valid;
	word_t data;
	strb_t keep;
	logic  last;
	// verdict so far becomes final on the last beat
	logic  drop;

	modport source (
		output valid, data, keep, last, drop
	);

	modport sink (
		input valid, data, keep, last, drop
	);

endinterface

/* src/dma_regs.sv */
`timescale 1ns/100ps

module dma_regs import eth_dma_pkg::*; (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  mem_valid,
	output logic                  mem_ready,
	input  addr_t                 mem_addr,
	input  word_t                 mem_wdata,
	input  strb_t                 mem_wstrb,
	output word_t                 mem_rdata,
	input  logic [desc_count-1:0] rx_status,
	input  byte_count_t           rx_len [desc_count],
	output addr_t                 rx_addr [desc_count],
	output logic                  dma_enable,
	output logic [desc_count-1:0] rx_clear
);

	logic      page_hit;
	logic      full_wr;
	logic      in_addr_blk;
	logic      in_len_blk;
	logic [7:0] offset;
	desc_idx_t idx;

	// ready blocks a repeated access
	assign page_hit = mem_valid && !mem_ready && (mem_addr[31:8] == reg_page);
	assign full_wr = (mem_wstrb == 4'hf);
	assign offset = mem_addr[7:0];
	assign idx = offset[4:2];
	assign in_addr_blk = (offset[7:5] == reg_rx_addr_base[7:5]);
	assign in_len_blk = (offset[7:5] == reg_rx_len_base[7:5]);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			mem_ready <= 1'b0;
			dma_enable <= 1'b0;
			rx_clear <= '0;
			for (int i = 0; i < desc_count; i++) begin
				rx_addr[i] <= '0;
			end
		end else begin
			mem_ready <= page_hit;
			rx_clear <= '0;
			if (page_hit && full_wr) begin
				if (in_addr_blk)
					rx_addr[idx] <= mem_wdata;
				else if (offset == reg_enable)
					dma_enable <= mem_wdata[0];
				else if (offset == reg_rx_clear)
					rx_clear <= mem_wdata[desc_count-1:0];
			end
		end
	end

	// registered read-back of the page
	always_ff @(posedge clk) begin
		if (page_hit) begin
			if (in_addr_blk)
				mem_rdata <= rx_addr[idx];
			else if (in_len_blk)
				mem_rdata <= word_t'(rx_len[idx]);
			else if (offset == reg_enable)
				mem_rdata <= word_t'(dma_enable);
			else if (offset == reg_rx_status)
				mem_rdata <= word_t'(rx_status);
			else
				mem_rdata <= '0;
		end
	end

	a_valid_dropped: assert property (@(posedge clk) disable iff (!resetn)
		mem_ready |=> !mem_valid);

endmodule

/* src/rx_frame_filter.sv */
`timescale 1ns/100ps

module rx_frame_filter import eth_dma_pkg::*; (
	input  logic  clk,
	input  logic  resetn,
	input  logic  rx_open,
	input  word_t rx_axis_tdata,
	input  strb_t rx_axis_tkeep,
	input  logic  rx_axis_tvalid,
	output logic  rx_axis_tready,
	input  logic  rx_axis_tlast,
	rx_beat_if.source beat
);

	logic        accept;
	byte_count_t cnt;
	byte_count_t cnt_next;
	logic [31:0] mac_hi;
	mac_t        dst_mac;
	logic        mac_hit;
	logic        drop_next;

	assign rx_axis_tready = rx_open;
	assign accept = rx_axis_tvalid && rx_open;
	assign cnt_next = cnt + byte_count_t'(keep_bytes(rx_axis_tkeep));

	// byte 0 sits in the lowest lane
	assign dst_mac = {mac_hi, rx_axis_tdata[7:0], rx_axis_tdata[15:8]};
	assign mac_hit = (dst_mac == own_mac) || (dst_mac == bcast_mac);

	always_comb begin
		if (cnt == 16'd0)
			drop_next = 1'b0;
		else if (cnt == 16'd4)
			drop_next = !mac_hit;
		else
			drop_next = beat.drop;
		// too short to hold a destination
		if (rx_axis_tlast && (cnt_next < 16'd6))
			drop_next = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			beat.valid <= 1'b0;
			cnt <= '0;
		end else begin
			beat.valid <= accept;
			if (accept)
				cnt <= rx_axis_tlast ? '0 : cnt_next;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			beat.data <= rx_axis_tdata;
			beat.keep <= rx_axis_tkeep;
			beat.last <= rx_axis_tlast;
			beat.drop <= drop_next;
			if (cnt == 16'd0)
				mac_hi <= {rx_axis_tdata[7:0], rx_axis_tdata[15:8],
					rx_axis_tdata[23:16], rx_axis_tdata[31:24]};
		end
	end

	a_keep_legal: assert property (@(posedge clk) disable iff (!resetn)
		accept |-> (rx_axis_tkeep inside {4'h1, 4'h3, 4'h7, 4'hf}));

endmodule

/* src/rx_heap_writer.sv */
`timescale 1ns/100ps

module rx_heap_writer import eth_dma_pkg::*; (
	input  logic        clk,
	input  logic        resetn,
	input  logic        dma_enable,
	input  logic        slot_free,
	input  addr_t       wr_base,
	output logic        bus_req,
	input  logic        bus_grant,
	input  logic        rx_axis_tvalid,
	output logic        rx_open,
	output logic        frame_done,
	output byte_count_t frame_len,
	output logic        frame_drop,
	rx_beat_if.sink     beat,
	heap_bus_if.master  heap
);

	typedef enum logic [2:0] {
		st_idle,
		st_wait,
		st_req,
		st_write,
		st_finish
	} state_t;

	state_t      state;
	state_t      state_next;
	addr_t       wr_addr;
	byte_count_t len_r;
	logic        drop_r;
	logic        last_beat;

	assign last_beat = beat.valid && beat.last;

	assign bus_req = (state == st_req) || (state == st_write);
	// closes as soon as the last beat leaves the filter
	assign rx_open = (state == st_write) && !last_beat;
	assign frame_done = (state == st_finish);
	assign frame_len = len_r;
	assign frame_drop = drop_r;

	assign heap.valid = (state == st_write) && beat.valid;
	assign heap.addr = wr_addr;
	assign heap.wdata = beat.data;
	assign heap.wstrb = beat.keep;

	always_comb begin
		state_next = state;
		case (state)
			st_idle:
				if (dma_enable)
					state_next = st_wait;
			st_wait:
				if (!dma_enable)
					state_next = st_idle;
				else if (rx_axis_tvalid && slot_free)
					state_next = st_req;
			st_req:
				if (bus_grant)
					state_next = st_write;
			st_write:
				if (last_beat)
					state_next = st_finish;
			st_finish:
				state_next = st_wait;
			default:
				state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			state <= st_idle;
		else
			state <= state_next;
	end

	always_ff @(posedge clk) begin
		if (state == st_req) begin
			wr_addr <= wr_base;
			len_r <= '0;
		end else if (heap.valid) begin
			wr_addr <= wr_addr + addr_t'(word_bytes);
			len_r <= len_r + byte_count_t'(keep_bytes(beat.keep));
		end
		if (last_beat)
			drop_r <= beat.drop;
	end

	a_write_granted: assert property (@(posedge clk) disable iff (!resetn)
		heap.valid |-> bus_grant);

endmodule

/* src/rx_desc_ring.sv */
`timescale 1ns/100ps

module rx_desc_ring import eth_dma_pkg::*; (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  dma_enable,
	input  logic                  frame_done,
	input  byte_count_t           frame_len,
	input  logic                  frame_drop,
	input  logic [desc_count-1:0] rx_clear,
	input  addr_t                 rx_addr [desc_count],
	output logic                  slot_free,
	output addr_t                 wr_base,
	output logic [desc_count-1:0] rx_status,
	output byte_count_t           rx_len [desc_count],
	output logic                  rx_irq
);

	localparam int irq_w = $clog2(rx_irq_interval + 1);

	desc_idx_t        idx;
	logic [irq_w-1:0] irq_cnt;

	// current slot is busy until the cpu clears it
	assign slot_free = !rx_status[idx];
	assign wr_base = rx_addr[idx];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			idx <= '0;
			rx_status <= '0;
			for (int i = 0; i < desc_count; i++) begin
				rx_len[i] <= '0;
			end
		end else begin
			if (frame_done && !frame_drop) begin
				rx_len[idx] <= frame_len;
				rx_status[idx] <= 1'b1;
				idx <= idx + desc_idx_t'(1);
			end
			for (int i = 0; i < desc_count; i++) begin
				if (rx_clear[i]) begin
					rx_status[i] <= 1'b0;
					rx_len[i] <= '0;
				end
			end
		end
	end

	// interval tick fires only with pending frames
	always_ff @(posedge clk) begin
		if (!resetn) begin
			irq_cnt <= '0;
			rx_irq <= 1'b0;
		end else begin
			rx_irq <= 1'b0;
			if (!dma_enable) begin
				irq_cnt <= '0;
			end else if (irq_cnt == irq_w'(rx_irq_interval)) begin
				irq_cnt <= '0;
				rx_irq <= |rx_status;
			end else begin
				irq_cnt <= irq_cnt + irq_w'(1);
			end
		end
	end

endmodule

/* src/heap_arbiter.sv */
`timescale 1ns/100ps

module heap_arbiter import eth_dma_pkg::*; (
	input  logic  clk,
	input  logic  resetn,
	input  logic  bus_req,
	output logic  bus_grant,
	heap_bus_if.slave dma,
	input  logic  cpu_heap_valid,
	output logic  cpu_heap_ready,
	input  addr_t cpu_heap_addr,
	input  word_t cpu_heap_wdata,
	input  strb_t cpu_heap_wstrb,
	output word_t cpu_heap_rdata,
	output logic  heap_valid,
	input  logic  heap_ready,
	output addr_t heap_addr,
	output word_t heap_wdata,
	output strb_t heap_wstrb,
	input  word_t heap_rdata
);

	// grant waits for a cycle without a cpu access
	always_ff @(posedge clk) begin
		if (!resetn)
			bus_grant <= 1'b0;
		else if (bus_req && !cpu_heap_valid)
			bus_grant <= 1'b1;
		else if (!bus_req)
			bus_grant <= 1'b0;
	end

	assign heap_valid = bus_grant ? dma.valid : cpu_heap_valid;
	assign heap_addr = bus_grant ? dma.addr : cpu_heap_addr;
	assign heap_wdata = bus_grant ? dma.wdata : cpu_heap_wdata;
	assign heap_wstrb = bus_grant ? dma.wstrb : cpu_heap_wstrb;

	assign dma.ready = bus_grant && heap_ready;
	assign dma.rdata = bus_grant ? heap_rdata : '0;
	assign cpu_heap_ready = !bus_grant && heap_ready;
	assign cpu_heap_rdata = bus_grant ? '0 : heap_rdata;

	// the writer never waits, so the heap must take every dma write
	a_dma_accepted: assert property (@(posedge clk) disable iff (!resetn)
		(bus_grant && dma.valid) |-> heap_ready);

endmodule

/* src/eth_rx_dma.sv */
`timescale 1ns/100ps

module eth_rx_dma import eth_dma_pkg::*; (
	input  logic  clk,
	input  logic  resetn,
	input  logic  mem_valid,
	output logic  mem_ready,
	input  addr_t mem_addr,
	input  word_t mem_wdata,
	input  strb_t mem_wstrb,
	output word_t mem_rdata,
	input  logic  cpu_heap_valid,
	output logic  cpu_heap_ready,
	input  addr_t cpu_heap_addr,
	input  word_t cpu_heap_wdata,
	input  strb_t cpu_heap_wstrb,
	output word_t cpu_heap_rdata,
	output logic  heap_valid,
	input  logic  heap_ready,
	output addr_t heap_addr,
	output word_t heap_wdata,
	output strb_t heap_wstrb,
	input  word_t heap_rdata,
	input  word_t rx_axis_tdata,
	input  strb_t rx_axis_tkeep,
	input  logic  rx_axis_tvalid,
	output logic  rx_axis_tready,
	input  logic  rx_axis_tlast,
	output logic  rx_irq
);

	heap_bus_if dma_bus ();
	rx_beat_if beat ();

	logic                  bus_req;
	logic                  bus_grant;
	logic                  rx_open;
	logic                  frame_done;
	byte_count_t           frame_len;
	logic                  frame_drop;
	logic                  slot_free;
	addr_t                 wr_base;
	logic                  dma_enable;
	logic [desc_count-1:0] rx_clear;
	logic [desc_count-1:0] rx_status;
	addr_t                 rx_addr [desc_count];
	byte_count_t           rx_len [desc_count];

	dma_regs regs_i (.*);

	rx_frame_filter filter_i (.*);

	rx_heap_writer writer_i (
		.*,
		.heap (dma_bus)
	);

	rx_desc_ring ring_i (.*);

	heap_arbiter arbiter_i (
		.*,
		.dma (dma_bus)
	);

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic resetn
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		resetn = 1'b0;
		repeat (2) @(posedge clk);
		resetn <= 1'b1;
	end

endmodule

/* sim/tb_eth_rx_dma.sv */
`timescale 1ns/100ps

module tb_eth_rx_dma import eth_dma_pkg::*; ();

	logic  clk;
	logic  resetn;
	logic  mem_valid, mem_ready;
	addr_t mem_addr;
	word_t mem_wdata, mem_rdata;
	strb_t mem_wstrb;
	logic  cpu_heap_valid, cpu_heap_ready;
	addr_t cpu_heap_addr;
	word_t cpu_heap_wdata, cpu_heap_rdata;
	strb_t cpu_heap_wstrb;
	logic  heap_valid, heap_ready;
	addr_t heap_addr;
	word_t heap_wdata, heap_rdata;
	strb_t heap_wstrb;
	word_t rx_axis_tdata;
	strb_t rx_axis_tkeep;
	logic  rx_axis_tvalid, rx_axis_tready, rx_axis_tlast;
	logic  rx_irq;

	word_t       heap_mem [4096];
	// addr, data, strobe of each DMA write still to come
	logic [67:0] exp_writes [$];
	logic [31:0] rng;
	logic [7:0]  exp_status;
	int          exp_len [desc_count];
	int          exp_idx;
	// high while no descriptor holds a frame
	logic        quiet;
	int          mismatches;
	int          failures;

	tb_clock clock_i (.clk, .resetn);

	eth_rx_dma dut_i (.*);

	// heap model accepting one access per cycle
	assign heap_ready = heap_valid;
	assign heap_rdata = heap_mem[heap_addr[13:2]];

	always @(negedge clk) begin
		logic [67:0] want;
		if (heap_valid) begin
			for (int b = 0; b < word_bytes; b++) begin
				if (heap_wstrb[b])
					heap_mem[heap_addr[13:2]][8*b +: 8] <= heap_wdata[8*b +: 8];
			end
			if (!cpu_heap_valid) begin
				assert (!cpu_heap_ready) else begin
					failures++;
					$display("cpu_heap_ready high during a DMA heap write");
				end
				if (exp_writes.size() == 0) begin
					failures++;
					$display("unexpected DMA heap write at %h", heap_addr);
				end else begin
					want = exp_writes.pop_front();
					check_value("heap_addr", heap_addr, want[67:36]);
					check_value("heap_wdata", heap_wdata, want[35:4]);
					check_value("heap_wstrb", word_t'(heap_wstrb), word_t'(want[3:0]));
				end
			end
		end
	end

	a_ready_follows: assert property (@(posedge clk) disable iff (!resetn)
		$rose(mem_valid) |=> mem_ready) else begin
		failures++;
		$display("mem_ready did not follow mem_valid after one cycle");
	end

	a_ready_single: assert property (@(posedge clk) disable iff (!resetn)
		mem_ready |=> !mem_ready) else begin
		failures++;
		$display("mem_ready stayed high for more than one cycle");
	end

	a_irq_single: assert property (@(posedge clk) disable iff (!resetn)
		rx_irq |=> !rx_irq) else begin
		failures++;
		$display("rx_irq stayed high for more than one cycle");
	end

	a_irq_quiet: assert property (@(posedge clk) disable iff (!resetn)
		rx_irq |-> !quiet) else begin
		failures++;
		$display("rx_irq pulsed while no descriptor held a frame");
	end

	a_tready_after_last: assert property (@(posedge clk) disable iff (!resetn)
		(rx_axis_tvalid && rx_axis_tready && rx_axis_tlast) |=> !rx_axis_tready) else begin
		failures++;
		$display("rx_axis_tready stayed high after the last beat");
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic addr_t desc_base(input int i);
		return 32'h1000 + 32'(i) * 32'h100;
	endfunction

	task automatic check_value(input string name, input word_t got, input word_t want);
		assert (got === want) else begin
			mismatches++;
			$display("Mismatch %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic end_run();
		$display("mismatches: %0d, other errors: %0d", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	task automatic abort_run(input string what);
		failures++;
		$display("timed out waiting for %s", what);
		end_run();
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (resetn !== 1'b1 && n < 10);
		if (resetn !== 1'b1)
			abort_run("reset release");
	endtask

	task automatic reg_access(input logic [7:0] offset, input word_t wdata, input strb_t strb,
			output word_t rdata);
		int n;
		@(posedge clk);
		mem_valid <= 1'b1;
		mem_addr <= {reg_page, offset};
		mem_wdata <= wdata;
		mem_wstrb <= strb;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!mem_ready && n < 20);
		if (!mem_ready)
			abort_run("mem_ready");
		rdata = mem_rdata;
		@(posedge clk);
		mem_valid <= 1'b0;
	endtask

	task automatic reg_check(input logic [7:0] offset, input string name, input word_t want);
		word_t rd;
		reg_access(offset, '0, 4'h0, rd);
		check_value(name, rd, want);
	endtask

	task automatic cpu_access(input addr_t addr, input word_t wdata, input strb_t strb,
			output word_t rdata);
		int n;
		@(posedge clk);
		cpu_heap_valid <= 1'b1;
		cpu_heap_addr <= addr;
		cpu_heap_wdata <= wdata;
		cpu_heap_wstrb <= strb;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!cpu_heap_ready && n < 20);
		if (!cpu_heap_ready)
			abort_run("cpu_heap_ready");
		rdata = cpu_heap_rdata;
		@(posedge clk);
		cpu_heap_valid <= 1'b0;
	endtask

	task automatic send_frame(input mac_t dst, input bit keep_it);
		int          nbytes;
		int          nwords;
		int          n;
		word_t       w;
		strb_t       k;
		addr_t       base;
		logic [35:0] beats [$];
		rng = xorshift(rng);
		nbytes = 6 + int'(rng % 35);
		nwords = (nbytes + 3) / 4;
		base = desc_base(exp_idx);
		for (int i = 0; i < nwords; i++) begin
			rng = xorshift(rng);
			w = rng;
			// first byte of the MAC goes in the lowest lane
			if (i == 0)
				w = {dst[23:16], dst[31:24], dst[39:32], dst[47:40]};
			if (i == 1)
				w[15:0] = {dst[7:0], dst[15:8]};
			if (i < nwords - 1 || nbytes % 4 == 0)
				k = 4'hf;
			else
				k = strb_t'((1 << (nbytes % 4)) - 1);
			beats.push_back({k, w});
			exp_writes.push_back({base + addr_t'(4 * i), w, k});
		end
		foreach (beats[i]) begin
			rng = xorshift(rng);
			if (rng[1:0] == 2'd0) begin
				@(posedge clk);
				rx_axis_tvalid <= 1'b0;
			end
			@(posedge clk);
			rx_axis_tvalid <= 1'b1;
			{rx_axis_tkeep, rx_axis_tdata} <= beats[i];
			rx_axis_tlast <= (i == beats.size() - 1);
			n = 0;
			do begin
				@(negedge clk);
				n++;
			end while (!rx_axis_tready && n < 100);
			if (!rx_axis_tready)
				abort_run("rx_axis_tready");
		end
		@(posedge clk);
		rx_axis_tvalid <= 1'b0;
		rx_axis_tlast <= 1'b0;
		n = 0;
		while (exp_writes.size() != 0 && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (exp_writes.size() != 0)
			abort_run("DMA heap writes");
		// frame_done then the ring commit
		repeat (2) @(posedge clk);
		if (keep_it) begin
			exp_status[exp_idx] = 1'b1;
			exp_len[exp_idx] = nbytes;
		end
		reg_check(reg_rx_status, "rx_status", word_t'(exp_status));
		reg_check(reg_rx_len_base + 8'(4 * exp_idx), "rx_len", word_t'(exp_len[exp_idx]));
		if (keep_it)
			exp_idx = (exp_idx + 1) % desc_count;
	endtask

	task automatic hold_blocked(input int cycles);
		@(posedge clk);
		rx_axis_tvalid <= 1'b1;
		rx_axis_tkeep <= 4'hf;
		repeat (cycles) begin
			@(negedge clk);
			assert (!rx_axis_tready) else begin
				failures++;
				$display("rx_axis_tready rose while every descriptor was full");
			end
		end
		@(posedge clk);
		rx_axis_tvalid <= 1'b0;
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!rx_irq && n < rx_irq_interval + 2);
		if (!rx_irq)
			abort_run("rx_irq");
	endtask

	initial begin
		word_t rd;
		mem_valid = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
		cpu_heap_valid = 1'b0;
		cpu_heap_addr = '0;
		cpu_heap_wdata = '0;
		cpu_heap_wstrb = '0;
		rx_axis_tdata = '0;
		rx_axis_tkeep = '0;
		rx_axis_tvalid = 1'b0;
		rx_axis_tlast = 1'b0;
		rng = 32'd49742;
		exp_status = '0;
		exp_idx = 0;
		quiet = 1'b1;
		mismatches = 0;
		failures = 0;
		foreach (exp_len[i])
			exp_len[i] = 0;
		wait_reset();

		for (int i = 0; i < desc_count; i++)
			reg_access(reg_rx_addr_base + 8'(4 * i), desc_base(i), 4'hf, rd);
		reg_access(reg_enable, 32'h1, 4'hf, rd);
		for (int i = 0; i < desc_count; i++)
			reg_check(reg_rx_addr_base + 8'(4 * i), "rx_addr", desc_base(i));
		reg_check(reg_enable, "dma_enable", 32'h1);

		// interval counter wraps once with no frame held
		repeat (rx_irq_interval + 10) @(posedge clk);
		cpu_access(32'h2000, 32'h5a3c_9617, 4'hf, rd);
		cpu_access(32'h2000, '0, 4'h0, rd);
		check_value("cpu_heap_rdata", rd, 32'h5a3c_9617);

		@(posedge clk);
		quiet <= 1'b0;
		send_frame(own_mac, 1'b1);
		wait_irq();
		send_frame(48'h02_11_22_33_44_55, 1'b0);
		for (int i = 0; i < 7; i++)
			send_frame((i % 2 == 1) ? own_mac : bcast_mac, 1'b1);

		// full ring keeps the stream stalled
		hold_blocked(40);
		reg_access(reg_rx_clear, 32'h1, 4'hf, rd);
		exp_status[0] = 1'b0;
		exp_len[0] = 0;
		reg_check(reg_rx_status, "rx_status", word_t'(exp_status));
		reg_check(reg_rx_len_base, "rx_len", 32'h0);
		send_frame(own_mac, 1'b1);

		reg_access(reg_rx_clear, 32'hff, 4'hf, rd);
		repeat (2) @(posedge clk);
		quiet <= 1'b1;
		repeat (rx_irq_interval + 10) @(posedge clk);
		end_run();
	end

endmodule

/* sim.f */
src/eth_dma_pkg.sv
src/heap_bus_if.sv
src/rx_beat_if.sv
src/dma_regs.sv
src/rx_frame_filter.sv
src/rx_heap_writer.sv
src/rx_desc_ring.sv
src/heap_arbiter.sv
src/eth_rx_dma.sv
sim/tb_clock.sv
sim/tb_eth_rx_dma.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_eth_rx_dma -o tb_eth_rx_dma
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_eth_rx_dma)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Simulation finished: PASS"; then
	exit 0
fi
exit 1
